/* verilog/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

	localparam int ADDR_W   = 32;  // Byte address
	localparam int LINE_W   = 128; // 16 bytes per line
	localparam int OFFSET_W = 4;
	localparam int INDEX_W  = 2;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	localparam int NUM_SETS = 1 << INDEX_W;
	localparam int NUM_WAYS = 2;

	// address = tag | index | offset
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [31:0]         word_t;
	typedef logic [LINE_W-1:0]   line_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

endpackage

`default_nettype wire

/* verilog/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

	import cache_geom_pkg::*;

	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;
	localparam int MEM_ADDR_W  = 8;  // Backing memory depth in lines
	localparam int MEM_LINES   = 1 << MEM_ADDR_W;
	localparam int MEM_LATENCY = 3;  // Wait cycles before mem_ack

	// Processor request, held until cpu_done
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  write;
		logic  byte_en;  // Byte access, else word
	} cpu_req_t;

	typedef struct packed {
		word_t rdata;
		logic  hit;  // Completed without a memory transaction
	} cpu_rsp_t;

	// Line-wide memory request
	typedef struct packed {
		logic [LINE_ADDR_W-1:0] line_addr;
		line_t                  wdata;
		logic                   write;
	} mem_req_t;

endpackage

`default_nettype wire

/* verilog/cache_way.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_way
	import cache_geom_pkg::*;
(
	input  wire          clk,
	input  wire          reset,
	input  wire index_t  index,
	input  wire tag_t    tag,
	input  wire offset_t offset,
	// Processor write, hit only
	input  wire          wr_en,
	input  wire          wr_byte,
	input  wire word_t   wr_data,
	// Line fill from memory
	input  wire          fill_en,
	input  wire line_t   fill_line,
	input  wire tag_t    fill_tag,
	output logic         hit,
	output logic         valid,
	output logic         dirty,
	output tag_t         stored_tag,
	output line_t        line
);

	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;
	tag_t                tags  [NUM_SETS];
	line_t               lines [NUM_SETS];

	// Lookup
	assign valid      = valid_bits[index];
	assign dirty      = dirty_bits[index];
	assign stored_tag = tags[index];
	assign line       = lines[index];
	assign hit        = valid && (stored_tag == tag);

	//////////////////////////////////////////////////////////////////////
	// Line and tag storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[index] <= fill_line;
			tags[index]  <= fill_tag;
		end else if (wr_en) begin
			if (wr_byte)
				lines[index][{offset, 3'b000} +: 8] <= wr_data[7:0];
			else
				lines[index][{offset[3:2], 5'b00000} +: 32] <= wr_data; // Word aligned
		end
	end

	// Valid and dirty state
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill_en) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= 1'b0; // Fresh copy of memory
		end else if (wr_en) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	// Controller never writes and fills the same way in one cycle
	a_wr_fill_excl: assert property (@(posedge clk) disable iff (reset)
		!(wr_en && fill_en))
		else $error("cache_way: write and fill together");

endmodule

`default_nettype wire

/* verilog/cache_2way.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_2way
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire cpu_req_t cpu_req,
	input  wire           cpu_req_valid,
	output cpu_rsp_t      cpu_rsp,
	output logic          cpu_done,
	// Memory side
	output mem_req_t      mem_req,
	output logic          mem_req_valid,
	input  wire           mem_ack,
	input  wire line_t    mem_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_BACK,
		FILL,
		DONE
	} state_t;

	state_t state;

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;

	logic [NUM_WAYS-1:0] way_hit;
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_dirty;
	logic [NUM_WAYS-1:0] way_wr;
	logic [NUM_WAYS-1:0] way_fill;
	tag_t                way_tag  [NUM_WAYS];
	line_t               way_line [NUM_WAYS];

	logic [NUM_SETS-1:0] lru;  // Per set, way to replace next
	logic     victim;          // Way chosen at the miss
	logic     victim_pick;
	logic     victim_dirty;
	logic     miss_seen;       // Access needed a fill
	logic     req_valid;
	logic     lookup;
	logic     any_hit;
	line_t    hit_line;
	word_t    hit_word;
	word_t    hit_byte;
	cpu_rsp_t rsp;

	assign req_tag    = cpu_req.addr[ADDR_W-1 -: TAG_W];
	assign req_index  = cpu_req.addr[OFFSET_W +: INDEX_W];
	assign req_offset = cpu_req.addr[OFFSET_W-1:0];

	assign lookup  = (state == IDLE) && cpu_req_valid;
	assign any_hit = |way_hit;

	//////////////////////////////////////////////////////////////////////
	// Ways
	//////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		assign way_wr[w]   = lookup && cpu_req.write && way_hit[w];
		assign way_fill[w] = (state == FILL) && mem_ack && (victim == 1'(w));

		cache_way u_way (
			.clk        (clk),
			.reset      (reset),
			.index      (req_index),
			.tag        (req_tag),
			.offset     (req_offset),
			.wr_en      (way_wr[w]),
			.wr_byte    (cpu_req.byte_en),
			.wr_data    (cpu_req.wdata),
			.fill_en    (way_fill[w]),
			.fill_line  (mem_rdata),
			.fill_tag   (req_tag),
			.hit        (way_hit[w]),
			.valid      (way_valid[w]),
			.dirty      (way_dirty[w]),
			.stored_tag (way_tag[w]),
			.line       (way_line[w])
		);
	end

	// Read data from the hit way
	assign hit_line = way_hit[1] ? way_line[1] : way_line[0];
	assign hit_word = hit_line[{req_offset[3:2], 5'b00000} +: 32];
	assign hit_byte = {24'h000000, hit_line[{req_offset, 3'b000} +: 8]};

	// Invalid way first, then LRU
	always_comb begin
		if (!way_valid[0])
			victim_pick = 1'b0;
		else if (!way_valid[1])
			victim_pick = 1'b1;
		else
			victim_pick = lru[req_index];
	end

	assign victim_dirty = way_valid[victim_pick] && way_dirty[victim_pick];

	// Write-back of the victim, else fill of the requested line
	always_comb begin
		mem_req.write = (state == WRITE_BACK);
		mem_req.wdata = way_line[victim];
		if (state == WRITE_BACK)
			mem_req.line_addr = {way_tag[victim], req_index};
		else
			mem_req.line_addr = {req_tag, req_index};
	end

	assign mem_req_valid = req_valid;
	assign cpu_done      = (state == DONE);
	assign cpu_rsp       = rsp;

	//////////////////////////////////////////////////////////////////////
	// Miss FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			lru       <= '0;
			victim    <= 1'b0;
			miss_seen <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (cpu_req_valid && any_hit) begin
						lru[req_index] <= way_hit[0]; // Other way goes next
						miss_seen      <= 1'b0;
						state          <= DONE;
					end else if (cpu_req_valid) begin
						victim    <= victim_pick;
						miss_seen <= 1'b1;
						req_valid <= 1'b1;
						state     <= victim_dirty ? WRITE_BACK : FILL;
					end
				end
				WRITE_BACK: begin
					if (mem_ack) begin
						req_valid <= 1'b0; // One idle cycle before the fill
						state     <= FILL;
					end
				end
				FILL: begin
					if (mem_ack) begin
						req_valid <= 1'b0;
						state     <= IDLE; // Retry the lookup
					end else if (!req_valid) begin
						req_valid <= 1'b1;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Response captured on the hit
	always_ff @(posedge clk) begin
		if (lookup && any_hit) begin
			rsp.rdata <= cpu_req.byte_en ? hit_byte : hit_word;
			rsp.hit   <= !miss_seen;
		end
	end

	a_one_hit: assert property (@(posedge clk) disable iff (reset)
		cpu_req_valid |-> !(way_hit[0] && way_hit[1]))
		else $error("cache_2way: line present in both ways");

	a_idle_no_mem: assert property (@(posedge clk) disable iff (reset)
		(state == IDLE) |-> !mem_req_valid)
		else $error("cache_2way: memory request left open in IDLE");

	a_done_held: assert property (@(posedge clk) disable iff (reset)
		cpu_done |-> cpu_req_valid)
		else $error("cache_2way: request dropped before done");

endmodule

`default_nettype wire

/* verilog/backing_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module backing_mem
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire mem_req_t mem_req,
	input  wire           mem_req_valid,
	output logic          mem_ack,
	output line_t         mem_rdata
);

	line_t                 lines [MEM_LINES];
	logic [MEM_LINES-1:0]  written;  // Line stored since reset
	logic [3:0]            lat_cnt;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic                  due;      // Request completes this cycle

	assign mem_addr = mem_req.line_addr[MEM_ADDR_W-1:0];
	assign due      = mem_req_valid && !mem_ack && (lat_cnt == 4'(MEM_LATENCY));

	//////////////////////////////////////////////////////////////////////
	// Latency counter and acknowledge
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			lat_cnt <= '0;
			mem_ack <= 1'b0;
			written <= '0;
		end else begin
			mem_ack <= due;
			if (mem_req_valid && !mem_ack && !due)
				lat_cnt <= lat_cnt + 4'd1;
			else
				lat_cnt <= '0; // Restart for the next request
			if (due && mem_req.write)
				written[mem_addr] <= 1'b1;
		end
	end

	// Storage and read port
	always_ff @(posedge clk) begin
		if (due && mem_req.write)
			lines[mem_addr] <= mem_req.wdata;
		if (due && !mem_req.write)
			mem_rdata <= written[mem_addr] ? lines[mem_addr] : '0; // Unwritten reads zero
	end

	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_ack |=> $stable(mem_req))
		else $error("backing_mem: request changed before mem_ack");

endmodule

`default_nettype wire

/* verilog/cache_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire cpu_req_t cpu_req,
	input  wire           cpu_req_valid,
	output cpu_rsp_t      cpu_rsp,
	output logic          cpu_done
);

	// Cache to memory
	mem_req_t mem_req;
	logic     mem_req_valid;
	logic     mem_ack;
	line_t    mem_rdata;

	cache_2way u_cache (
		.clk           (clk),
		.reset         (reset),
		.cpu_req       (cpu_req),
		.cpu_req_valid (cpu_req_valid),
		.cpu_rsp       (cpu_rsp),
		.cpu_done      (cpu_done),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata)
	);

	backing_mem u_mem (
		.clk           (clk),
		.reset         (reset),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata)
	);

endmodule

`default_nettype wire

/* testbench/tb_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cache
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int ACCESS_LIMIT = 40;     // Cycles allowed for one access
	localparam int RANDOM_OPS   = 150;
	// About 200 accesses at 15 cycles worst case, doubled, rounded up
	localparam int WATCHDOG_NS  = 50_000;

	logic     clk;
	logic     reset;
	cpu_req_t cpu_req;
	logic     cpu_req_valid;
	cpu_rsp_t cpu_rsp;
	logic     cpu_done;

	logic [7:0] shadow [4096];  // Expected contents of the low 4 KB
	int         pass_count;
	int         fail_count;
	integer     seed;

	cache_subsystem u_dut (
		.clk           (clk),
		.reset         (reset),
		.cpu_req       (cpu_req),
		.cpu_req_valid (cpu_req_valid),
		.cpu_rsp       (cpu_rsp),
		.cpu_done      (cpu_done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Shadow model and checking
	//////////////////////////////////////////////////////////////////////

	// Zero-extended byte, or little-endian word
	function automatic word_t shadow_read(input logic byte_en, input addr_t addr);
		logic [11:0] base;
		base = {addr[11:2], 2'b00};
		if (byte_en)
			return {24'h000000, shadow[addr[11:0]]};
		return {shadow[base + 12'd3], shadow[base + 12'd2], shadow[base + 12'd1], shadow[base]};
	endfunction

	function automatic void shadow_write(input logic byte_en, input addr_t addr, input word_t wdata);
		logic [11:0] base;
		base = {addr[11:2], 2'b00};
		if (byte_en) begin
			shadow[addr[11:0]] = wdata[7:0];
		end else begin
			shadow[base]         = wdata[7:0];
			shadow[base + 12'd1] = wdata[15:8];
			shadow[base + 12'd2] = wdata[23:16];
			shadow[base + 12'd3] = wdata[31:24];
		end
	endfunction

	task automatic check(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, expected);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// Holds the request until cpu_done, then releases it a cycle later
	task automatic access(input logic write, input logic byte_en, input addr_t addr,
		input word_t wdata, output word_t rdata, output logic hit);
		int cycles;
		cycles                = 0;
		cpu_req.addr          = addr;
		cpu_req.wdata         = wdata;
		cpu_req.write         = write;
		cpu_req.byte_en       = byte_en;
		cpu_req_valid         = 1'b1;
		@(posedge clk);
		#1;
		while (!cpu_done && cycles < ACCESS_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!cpu_done) begin
			$display("Access to %h got no cpu_done within %0d cycles", addr, ACCESS_LIMIT);
			fail_count++;
			rdata = '0;
			hit   = 1'b0;
		end else begin
			rdata = cpu_rsp.rdata;
			hit   = cpu_rsp.hit;
		end
		@(posedge clk);
		#1;
		cpu_req_valid = 1'b0;
	endtask

	task automatic read_compare(input string name, input logic byte_en, input addr_t addr,
		output logic hit);
		word_t rdata;
		word_t expected;
		expected = shadow_read(byte_en, addr);
		access(1'b0, byte_en, addr, '0, rdata, hit);
		check(name, rdata, expected);
	endtask

	task automatic write_data(input logic byte_en, input addr_t addr, input word_t wdata,
		output logic hit);
		word_t rdata;
		access(1'b1, byte_en, addr, wdata, rdata, hit);
		shadow_write(byte_en, addr, wdata);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic cold_miss_test();
		int   errors;
		logic hit;
		errors = fail_count;
		read_compare("cpu_rsp.rdata (cold read)", 1'b0, 32'h0000_0100, hit);
		check("cpu_rsp.hit (cold read)", word_t'(hit), 32'd0);
		write_data(1'b0, 32'h0000_0104, 32'hdead_beef, hit);
		check("cpu_rsp.hit (word write)", word_t'(hit), 32'd1);
		read_compare("cpu_rsp.rdata (byte read)", 1'b1, 32'h0000_0105, hit);
		check("cpu_rsp.hit (byte read)", word_t'(hit), 32'd1);
		$display("cold_miss_test: finished, %0d errors", fail_count - errors);
	endtask

	task automatic byte_merge_test();
		int   errors;
		logic hit;
		errors = fail_count;
		for (int i = 0; i < 4; i++)
			write_data(1'b1, 32'h0000_0208 + addr_t'(i), word_t'(32'h11 * (i + 1)), hit);
		read_compare("cpu_rsp.rdata (merged word)", 1'b0, 32'h0000_0208, hit);
		read_compare("cpu_rsp.rdata (merged byte)", 1'b1, 32'h0000_020a, hit);
		$display("byte_merge_test: finished, %0d errors", fail_count - errors);
	endtask

	// Tags A, B, C share set 1
	task automatic eviction_test();
		int   errors;
		logic hit;
		errors = fail_count;
		write_data(1'b0, 32'h0000_0410, 32'haaaa_0001, hit);
		write_data(1'b0, 32'h0000_0810, 32'hbbbb_0002, hit);
		write_data(1'b0, 32'h0000_0c10, 32'hcccc_0003, hit);
		check("cpu_rsp.hit (write C)", word_t'(hit), 32'd0);
		read_compare("cpu_rsp.rdata (reread B)", 1'b0, 32'h0000_0810, hit);
		check("cpu_rsp.hit (reread B)", word_t'(hit), 32'd1);  // A was the victim
		read_compare("cpu_rsp.rdata (reread A)", 1'b0, 32'h0000_0410, hit);
		check("cpu_rsp.hit (reread A)", word_t'(hit), 32'd0);
		read_compare("cpu_rsp.rdata (reread C)", 1'b0, 32'h0000_0c10, hit);
		$display("eviction_test: finished, %0d errors", fail_count - errors);
	endtask

	task automatic lru_test();
		int    errors;
		logic  hit;
		addr_t seq_addr [6];
		logic  seq_wr   [6];
		word_t seq_data [6];
		logic  seq_hit  [6];
		errors   = fail_count;
		// A to way 0, B to way 1, A hits, C replaces B, A hits, B misses
		seq_addr = '{32'h0000_0420, 32'h0000_0820, 32'h0000_0420,
			32'h0000_0c20, 32'h0000_0420, 32'h0000_0820};
		// First touch of each tag is a write, giving every line its own data
		seq_wr   = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
		seq_data = '{32'haaaa_0020, 32'hbbbb_0020, 32'h0,
			32'hcccc_0020, 32'h0, 32'h0};
		seq_hit  = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
		for (int i = 0; i < 6; i++) begin
			if (seq_wr[i])
				write_data(1'b0, seq_addr[i], seq_data[i], hit);
			else
				read_compare($sformatf("cpu_rsp.rdata (lru step %0d)", i), 1'b0,
					seq_addr[i], hit);
			check($sformatf("cpu_rsp.hit (lru step %0d)", i), word_t'(hit), word_t'(seq_hit[i]));
		end
		$display("lru_test: finished, %0d errors", fail_count - errors);
	endtask

	// 32 lines, 8 tags per set
	task automatic random_test();
		int          errors;
		logic        hit;
		logic [31:0] r;
		logic        is_byte;
		offset_t     off;
		addr_t       addr;
		word_t       wdata;
		errors = fail_count;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r       = $random(seed);
			wdata   = $random(seed);
			is_byte = r[10];
			off     = is_byte ? r[8:5] : {r[8:7], 2'b00};
			addr    = {20'h00000, r[4:2], 3'b000, r[1:0], off};
			if (r[9])
				write_data(is_byte, addr, wdata, hit);
			else
				read_compare("cpu_rsp.rdata (random)", is_byte, addr, hit);
		end
		$display("random_test: finished, %0d errors", fail_count - errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed          = 32'h0dcfba6b;
		clk           = 1'b0;
		reset         = 1'b1;
		cpu_req       = '0;
		cpu_req_valid = 1'b0;
		pass_count    = 0;
		fail_count    = 0;
		for (int i = 0; i < 4096; i++)
			shadow[i] = 8'h00;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		cold_miss_test();
		byte_merge_test();
		eviction_test();
		lru_test();
		random_test();

		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
verilog/cache_geom_pkg.sv
verilog/mem_bus_pkg.sv
verilog/cache_way.sv
verilog/cache_2way.sv
verilog/backing_mem.sv
verilog/cache_subsystem.sv
testbench/tb_cache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cache
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
